// File: design/axi_mux_pkg.sv
// ----------------------------------------
// AXI write mux types
// ----------------------------------------
`default_nettype none

package axi_mux_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int unsigned SlvIdWidth   = 4;
    localparam int unsigned PortIdxWidth = 2;   // Up to four slave ports
    localparam int unsigned MstIdWidth   = SlvIdWidth + PortIdxWidth;
    localparam int unsigned AddrWidth    = 32;
    localparam int unsigned DataWidth    = 32;
    localparam int unsigned StrbWidth    = DataWidth / 8;

    typedef logic [PortIdxWidth-1:0] port_idx_t;

    // ----------------------------------------
    // Channel payloads
    // ----------------------------------------
    typedef struct packed {
        logic [SlvIdWidth-1:0] id;
        logic [AddrWidth-1:0]  addr;
        logic [7:0]            len;     // Beats minus one
    } aw_slv_t;

    typedef struct packed {
        logic [MstIdWidth-1:0] id;      // Port index on top
        logic [AddrWidth-1:0]  addr;
        logic [7:0]            len;
    } aw_mst_t;

    typedef struct packed {
        logic [DataWidth-1:0] data;
        logic [StrbWidth-1:0] strb;
        logic                 last;
    } w_chan_t;

    typedef struct packed {
        logic [SlvIdWidth-1:0] id;
        logic [1:0]            resp;
    } b_slv_t;

    typedef struct packed {
        logic [MstIdWidth-1:0] id;
        logic [1:0]            resp;
    } b_mst_t;

endpackage

`default_nettype wire

// File: design/axi_rr_arbiter.sv
// ----------------------------------------
// Round-robin arbiter with lock-in
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi_rr_arbiter #(
    parameter int unsigned NumSlvPorts = 4
) (
    input  wire logic                                    clk_i,
    input  wire logic                                    rst_i,
    input  wire logic [NumSlvPorts-1:0]                  req_i,
    input  wire axi_mux_pkg::aw_slv_t [NumSlvPorts-1:0]  data_i,
    output logic [NumSlvPorts-1:0]                       gnt_o,
    output logic                                         valid_o,
    input  wire logic                                    ready_i,
    output axi_mux_pkg::aw_slv_t                         data_o,
    output axi_mux_pkg::port_idx_t                       idx_o
);

    axi_mux_pkg::port_idx_t ptr_q;      // First port to look at
    axi_mux_pkg::port_idx_t lock_idx_q;
    logic                   lock_q;     // Stalled offer must not change
    axi_mux_pkg::port_idx_t rr_idx;
    axi_mux_pkg::port_idx_t sel_idx;

    // Search from the pointer, the lowest offset wins
    always_comb begin
        int unsigned cand;
        rr_idx = ptr_q;
        for (int i = NumSlvPorts - 1; i >= 0; i--) begin
            cand = (int'(ptr_q) + i) % NumSlvPorts;
            if (req_i[cand]) begin
                rr_idx = axi_mux_pkg::port_idx_t'(cand);
            end
        end
    end

    assign sel_idx = lock_q ? lock_idx_q : rr_idx;
    assign valid_o = lock_q ? req_i[lock_idx_q] : |req_i;
    assign data_o  = data_i[sel_idx];
    assign idx_o   = sel_idx;

    always_comb begin
        gnt_o          = '0;
        gnt_o[sel_idx] = valid_o & ready_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ptr_q      <= '0;
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else begin
            lock_q <= valid_o & ~ready_i;
            if (valid_o && !ready_i) begin
                lock_idx_q <= sel_idx;
            end
            if (valid_o && ready_i) begin  // Move past the winner
                ptr_q <= (int'(sel_idx) + 1 == NumSlvPorts) ? '0 : sel_idx + 1'b1;
            end
        end
    end

    // AXI stability of the offered request
    assert property (@(posedge clk_i) disable iff (rst_i)
        valid_o && !ready_i |=> valid_o && $stable(data_o) && $stable(idx_o));

endmodule

`default_nettype wire

// File: design/axi_spill_register.sv
// ----------------------------------------
// Two-entry spill register
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi_spill_register (
    input  wire logic                  clk_i,
    input  wire logic                  rst_i,
    input  wire logic                  valid_i,
    output logic                       ready_o,
    input  wire axi_mux_pkg::aw_mst_t  data_i,
    output logic                       valid_o,
    input  wire logic                  ready_i,
    output axi_mux_pkg::aw_mst_t       data_o
);

    axi_mux_pkg::aw_mst_t a_data_q;     // Output slot
    axi_mux_pkg::aw_mst_t b_data_q;     // Overflow slot
    logic                 a_full_q;
    logic                 b_full_q;
    logic                 in_xfer;
    logic                 out_xfer;

    assign ready_o  = ~b_full_q;
    assign valid_o  = a_full_q;
    assign data_o   = a_data_q;
    assign in_xfer  = valid_i & ready_o;
    assign out_xfer = a_full_q & ready_i;

    // ----------------------------------------
    // Slot control
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            a_full_q <= 1'b0;
            b_full_q <= 1'b0;
        end else if (b_full_q) begin
            if (out_xfer) begin
                b_full_q <= 1'b0;           // B refills A
            end
        end else if (in_xfer) begin
            if (a_full_q && !ready_i) begin
                b_full_q <= 1'b1;
            end else begin
                a_full_q <= 1'b1;
            end
        end else if (out_xfer) begin
            a_full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (b_full_q && out_xfer) begin
            a_data_q <= b_data_q;
        end else if (in_xfer && !(a_full_q && !ready_i)) begin
            a_data_q <= data_i;
        end
        if (in_xfer && a_full_q && !ready_i) begin
            b_data_q <= data_i;
        end
    end

    // Output held without ready must not change
    assert property (@(posedge clk_i) disable iff (rst_i)
        valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

`default_nettype wire

// File: design/axi_w_route_fifo.sv
// ----------------------------------------
// W routing FIFO
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi_w_route_fifo #(
    parameter int unsigned MaxWTrans = 4
) (
    input  wire logic                    clk_i,
    input  wire logic                    rst_i,
    input  wire logic                    push_i,
    input  wire axi_mux_pkg::port_idx_t  data_i,
    output logic                         full_o,
    input  wire logic                    pop_i,
    output axi_mux_pkg::port_idx_t       data_o,
    output logic                         empty_o
);

    localparam int unsigned PtrWidth = (MaxWTrans > 1) ? $clog2(MaxWTrans) : 1;
    localparam int unsigned CntWidth = $clog2(MaxWTrans + 1);

    axi_mux_pkg::port_idx_t mem_q [0:MaxWTrans-1];
    logic [PtrWidth-1:0]    wr_ptr_q;
    logic [PtrWidth-1:0]    rd_ptr_q;
    logic [CntWidth-1:0]    count_q;

    assign full_o  = (count_q == CntWidth'(MaxWTrans));
    assign empty_o = (count_q == '0);
    assign data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PtrWidth'(MaxWTrans - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PtrWidth'(MaxWTrans - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // AW side holds off when full, W side only pops a live head
    assert property (@(posedge clk_i) disable iff (rst_i) push_i |-> !full_o);
    assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_o);

endmodule

`default_nettype wire

// File: design/axi_aw_channel.sv
// ----------------------------------------
// AW arbitration and ID prepend
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi_aw_channel #(
    parameter int unsigned NumSlvPorts = 4
) (
    input  wire logic                                    clk_i,
    input  wire logic                                    rst_i,
    input  wire axi_mux_pkg::aw_slv_t [NumSlvPorts-1:0]  slv_aw_i,
    input  wire logic [NumSlvPorts-1:0]                  slv_aw_valid_i,
    output logic [NumSlvPorts-1:0]                       slv_aw_ready_o,
    output axi_mux_pkg::aw_mst_t                         mst_aw_o,
    output logic                                         mst_aw_valid_o,
    input  wire logic                                    mst_aw_ready_i,
    input  wire logic                                    route_full_i,
    output logic                                         route_push_o,
    output axi_mux_pkg::port_idx_t                       route_idx_o
);

    axi_mux_pkg::aw_slv_t   arb_aw;
    axi_mux_pkg::port_idx_t arb_idx;
    logic                   arb_valid;
    logic                   arb_ready;
    axi_mux_pkg::aw_mst_t   aw_prep;    // ID with port index on top
    logic                   aw_valid;
    logic                   spill_ready;
    logic                   lock_d;
    logic                   lock_q;     // Index already pushed, AW still waiting

    axi_rr_arbiter #(
        .NumSlvPorts(NumSlvPorts)
    ) u_arbiter (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .req_i  (slv_aw_valid_i),
        .data_i (slv_aw_i),
        .gnt_o  (slv_aw_ready_o),
        .valid_o(arb_valid),
        .ready_i(arb_ready),
        .data_o (arb_aw),
        .idx_o  (arb_idx)
    );

    assign aw_prep.id   = {arb_idx, arb_aw.id};
    assign aw_prep.addr = arb_aw.addr;
    assign aw_prep.len  = arb_aw.len;
    assign route_idx_o  = arb_idx;

    // ----------------------------------------
    // Push once per AW, hold valid while stalled
    // ----------------------------------------
    always_comb begin
        lock_d       = lock_q;
        route_push_o = 1'b0;
        aw_valid     = 1'b0;
        arb_ready    = 1'b0;
        if (lock_q) begin
            aw_valid = 1'b1;
            if (spill_ready) begin
                arb_ready = 1'b1;
                lock_d    = 1'b0;
            end
        end else if (arb_valid && !route_full_i) begin
            aw_valid     = 1'b1;
            route_push_o = 1'b1;
            if (spill_ready) begin
                arb_ready = 1'b1;
            end else begin
                lock_d = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            lock_q <= 1'b0;
        end else begin
            lock_q <= lock_d;
        end
    end

    axi_spill_register u_aw_spill (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .valid_i(aw_valid),
        .ready_o(spill_ready),
        .data_i (aw_prep),
        .valid_o(mst_aw_valid_o),
        .ready_i(mst_aw_ready_i),
        .data_o (mst_aw_o)
    );

endmodule

`default_nettype wire

// File: design/axi_w_channel.sv
// ----------------------------------------
// W beat steering
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi_w_channel #(
    parameter int unsigned NumSlvPorts = 4
) (
    input  wire axi_mux_pkg::w_chan_t [NumSlvPorts-1:0]  slv_w_i,
    input  wire logic [NumSlvPorts-1:0]                  slv_w_valid_i,
    output logic [NumSlvPorts-1:0]                       slv_w_ready_o,
    output axi_mux_pkg::w_chan_t                         mst_w_o,
    output logic                                         mst_w_valid_o,
    input  wire logic                                    mst_w_ready_i,
    input  wire axi_mux_pkg::port_idx_t                  route_idx_i,
    input  wire logic                                    route_empty_i,
    output logic                                         route_pop_o
);

    assign mst_w_o = slv_w_i[route_idx_i];  // Head port only

    always_comb begin
        mst_w_valid_o = 1'b0;
        slv_w_ready_o = '0;
        route_pop_o   = 1'b0;
        if (!route_empty_i) begin
            mst_w_valid_o              = slv_w_valid_i[route_idx_i];
            slv_w_ready_o[route_idx_i] = mst_w_ready_i;
            // Burst done, next AW grant takes over
            route_pop_o = slv_w_valid_i[route_idx_i] & mst_w_ready_i & mst_w_o.last;
        end
    end

endmodule

`default_nettype wire

// File: design/axi_b_channel.sv
// ----------------------------------------
// B response routing
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi_b_channel #(
    parameter int unsigned NumSlvPorts = 4
) (
    input  wire axi_mux_pkg::b_mst_t                 mst_b_i,
    input  wire logic                                mst_b_valid_i,
    output logic                                     mst_b_ready_o,
    output axi_mux_pkg::b_slv_t [NumSlvPorts-1:0]    slv_b_o,
    output logic [NumSlvPorts-1:0]                   slv_b_valid_o,
    input  wire logic [NumSlvPorts-1:0]              slv_b_ready_i
);

    axi_mux_pkg::port_idx_t b_idx;
    axi_mux_pkg::b_slv_t    b_stripped;

    // Index sits in the top ID bits
    assign b_idx = mst_b_i.id[axi_mux_pkg::MstIdWidth-1 -: axi_mux_pkg::PortIdxWidth];

    assign b_stripped.id   = mst_b_i.id[axi_mux_pkg::SlvIdWidth-1:0];
    assign b_stripped.resp = mst_b_i.resp;
    assign slv_b_o         = {NumSlvPorts{b_stripped}};     // Valid picks the port

    always_comb begin
        slv_b_valid_o        = '0;
        slv_b_valid_o[b_idx] = mst_b_valid_i;
    end

    assign mst_b_ready_o = slv_b_ready_i[b_idx];

    // Master side must only answer IDs this mux handed out
    always_comb begin
        assert final (!mst_b_valid_i || (int'(b_idx) < NumSlvPorts));
    end

endmodule

`default_nettype wire

// File: design/axi_mux_top.sv
// ----------------------------------------
// AXI write mux top
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi_mux_top #(
    parameter int unsigned NumSlvPorts = 4,
    parameter int unsigned MaxWTrans   = 4
) (
    input  wire logic                                    clk_i,
    input  wire logic                                    rst_i,
    // Slave ports
    input  wire axi_mux_pkg::aw_slv_t [NumSlvPorts-1:0]  slv_aw_i,
    input  wire logic [NumSlvPorts-1:0]                  slv_aw_valid_i,
    output logic [NumSlvPorts-1:0]                       slv_aw_ready_o,
    input  wire axi_mux_pkg::w_chan_t [NumSlvPorts-1:0]  slv_w_i,
    input  wire logic [NumSlvPorts-1:0]                  slv_w_valid_i,
    output logic [NumSlvPorts-1:0]                       slv_w_ready_o,
    output axi_mux_pkg::b_slv_t [NumSlvPorts-1:0]        slv_b_o,
    output logic [NumSlvPorts-1:0]                       slv_b_valid_o,
    input  wire logic [NumSlvPorts-1:0]                  slv_b_ready_i,
    // Master port
    output axi_mux_pkg::aw_mst_t                         mst_aw_o,
    output logic                                         mst_aw_valid_o,
    input  wire logic                                    mst_aw_ready_i,
    output axi_mux_pkg::w_chan_t                         mst_w_o,
    output logic                                         mst_w_valid_o,
    input  wire logic                                    mst_w_ready_i,
    input  wire axi_mux_pkg::b_mst_t                     mst_b_i,
    input  wire logic                                    mst_b_valid_i,
    output logic                                         mst_b_ready_o
);

    logic                   route_push;
    axi_mux_pkg::port_idx_t aw_route_idx;   // Grant going in
    logic                   route_full;
    logic                   route_pop;
    axi_mux_pkg::port_idx_t w_route_idx;    // Head coming out
    logic                   route_empty;

    axi_aw_channel #(
        .NumSlvPorts(NumSlvPorts)
    ) u_aw_channel (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .slv_aw_i      (slv_aw_i),
        .slv_aw_valid_i(slv_aw_valid_i),
        .slv_aw_ready_o(slv_aw_ready_o),
        .mst_aw_o      (mst_aw_o),
        .mst_aw_valid_o(mst_aw_valid_o),
        .mst_aw_ready_i(mst_aw_ready_i),
        .route_full_i  (route_full),
        .route_push_o  (route_push),
        .route_idx_o   (aw_route_idx)
    );

    axi_w_route_fifo #(
        .MaxWTrans(MaxWTrans)
    ) u_route_fifo (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .push_i (route_push),
        .data_i (aw_route_idx),
        .full_o (route_full),
        .pop_i  (route_pop),
        .data_o (w_route_idx),
        .empty_o(route_empty)
    );

    axi_w_channel #(
        .NumSlvPorts(NumSlvPorts)
    ) u_w_channel (
        .slv_w_i      (slv_w_i),
        .slv_w_valid_i(slv_w_valid_i),
        .slv_w_ready_o(slv_w_ready_o),
        .mst_w_o      (mst_w_o),
        .mst_w_valid_o(mst_w_valid_o),
        .mst_w_ready_i(mst_w_ready_i),
        .route_idx_i  (w_route_idx),
        .route_empty_i(route_empty),
        .route_pop_o  (route_pop)
    );

    axi_b_channel #(
        .NumSlvPorts(NumSlvPorts)
    ) u_b_channel (
        .mst_b_i      (mst_b_i),
        .mst_b_valid_i(mst_b_valid_i),
        .mst_b_ready_o(mst_b_ready_o),
        .slv_b_o      (slv_b_o),
        .slv_b_valid_o(slv_b_valid_o),
        .slv_b_ready_i(slv_b_ready_i)
    );

endmodule

`default_nettype wire

// File: tb/axi_mux_tb.sv
// ----------------------------------------
// AXI write mux testbench
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi_mux_tb;

    localparam int unsigned NumSlvPorts = 4;
    localparam int unsigned MaxWTrans   = 4;
    localparam int unsigned MaxLines    = 64;
    localparam int unsigned StallCycles = 40;   // W held off after reset

    logic                                    clk_i;
    logic                                    rst_i;
    axi_mux_pkg::aw_slv_t [NumSlvPorts-1:0]  slv_aw_i;
    logic [NumSlvPorts-1:0]                  slv_aw_valid_i;
    logic [NumSlvPorts-1:0]                  slv_aw_ready_o;
    axi_mux_pkg::w_chan_t [NumSlvPorts-1:0]  slv_w_i;
    logic [NumSlvPorts-1:0]                  slv_w_valid_i;
    logic [NumSlvPorts-1:0]                  slv_w_ready_o;
    axi_mux_pkg::b_slv_t [NumSlvPorts-1:0]   slv_b_o;
    logic [NumSlvPorts-1:0]                  slv_b_valid_o;
    logic [NumSlvPorts-1:0]                  slv_b_ready_i;
    axi_mux_pkg::aw_mst_t                    mst_aw_o;
    logic                                    mst_aw_valid_o;
    logic                                    mst_aw_ready_i;
    axi_mux_pkg::w_chan_t                    mst_w_o;
    logic                                    mst_w_valid_o;
    logic                                    mst_w_ready_i;
    axi_mux_pkg::b_mst_t                     mst_b_i;
    logic                                    mst_b_valid_i;
    logic                                    mst_b_ready_o;

    // ----------------------------------------
    // Transaction table from the input file
    // ----------------------------------------
    logic [1:0]  t_port   [0:MaxLines-1];
    logic [3:0]  t_id     [0:MaxLines-1];
    logic [31:0] t_addr   [0:MaxLines-1];
    logic [7:0]  t_len    [0:MaxLines-1];
    logic [1:0]  t_resp   [0:MaxLines-1];
    logic [5:0]  t_mst_id [0:MaxLines-1];  // As seen on the master AW
    bit          t_aw_done [0:MaxLines-1];
    bit          t_w_done  [0:MaxLines-1];
    int          port_lines [NumSlvPorts][$];
    int          num_lines;
    bit          loaded;

    // Source and model state
    int aw_next [NumSlvPorts];
    int w_next  [NumSlvPorts];
    int w_beat  [NumSlvPorts];
    int b_next  [NumSlvPorts];
    bit aw_taken [NumSlvPorts];
    int aw_order [$];       // Grant order, expected at master AW
    int w_order  [$];       // Grant order, expected at master W
    int b_pending [$];
    bit b_taken;
    int mst_beat;
    int mst_aw_count;
    int aw_before_w;
    int w_beat_total;
    int burst_count;
    int b_count;
    int cycle_count;
    int value_errors;
    int other_errors;

    axi_mux_top #(
        .NumSlvPorts(NumSlvPorts),
        .MaxWTrans  (MaxWTrans)
    ) dut (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .slv_aw_i      (slv_aw_i),
        .slv_aw_valid_i(slv_aw_valid_i),
        .slv_aw_ready_o(slv_aw_ready_o),
        .slv_w_i       (slv_w_i),
        .slv_w_valid_i (slv_w_valid_i),
        .slv_w_ready_o (slv_w_ready_o),
        .slv_b_o       (slv_b_o),
        .slv_b_valid_o (slv_b_valid_o),
        .slv_b_ready_i (slv_b_ready_i),
        .mst_aw_o      (mst_aw_o),
        .mst_aw_valid_o(mst_aw_valid_o),
        .mst_aw_ready_i(mst_aw_ready_i),
        .mst_w_o       (mst_w_o),
        .mst_w_valid_o (mst_w_valid_o),
        .mst_w_ready_i (mst_w_ready_i),
        .mst_b_i       (mst_b_i),
        .mst_b_valid_i (mst_b_valid_i),
        .mst_b_ready_o (mst_b_ready_o)
    );

    always #50 clk_i = ~clk_i;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] beat_data(int line, int k);
        return {6'b0, t_port[line], 4'b0, t_id[line], t_addr[line][7:0], 8'(k)};
    endfunction

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("FAIL t=%0t %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    function automatic bit require(bit cond, string what);
        assert (cond) else begin
            other_errors++;
            $display("ERROR t=%0t: %s", $time, what);
        end
        return cond;
    endfunction

    task automatic load_transactions();
        int          fd;
        int          r;
        string       s;
        logic [31:0] f_port;
        logic [31:0] f_id;
        logic [31:0] f_addr;
        logic [31:0] f_len;
        logic [31:0] f_resp;
        num_lines = 0;
        fd = $fopen("tb/axi_mux_input.txt", "r");
        if (!require(fd != 0, "cannot open tb/axi_mux_input.txt")) begin
            return;
        end
        while (!$feof(fd)) begin
            s = "";
            r = $fgets(s, fd);
            if (r > 0 && s.len() > 1 && s[0] != "#") begin
                r = $sscanf(s, "%h %h %h %h %h", f_port, f_id, f_addr, f_len, f_resp);
                if (require(r == 5 && f_port < NumSlvPorts && num_lines < MaxLines,
                            "malformed line in input file")) begin
                    t_port[num_lines]    = f_port[1:0];
                    t_id[num_lines]      = f_id[3:0];
                    t_addr[num_lines]    = f_addr;
                    t_len[num_lines]     = f_len[7:0];
                    t_resp[num_lines]    = f_resp[1:0];
                    t_aw_done[num_lines] = 1'b0;
                    t_w_done[num_lines]  = 1'b0;
                    port_lines[f_port].push_back(num_lines);
                    num_lines++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_idle_outputs();
        check_value("mst_aw_valid_o", mst_aw_valid_o, 1'b0);
        check_value("mst_w_valid_o", mst_w_valid_o, 1'b0);
        check_value("slv_b_valid_o", slv_b_valid_o, '0);
    endtask

    // ----------------------------------------
    // Sampling at the rising edge
    // ----------------------------------------
    task automatic sample_slave_side();
        int line;
        for (int p = 0; p < NumSlvPorts; p++) begin
            if (slv_aw_valid_i[p] && slv_aw_ready_o[p]) begin
                line = port_lines[p][aw_next[p]];
                aw_order.push_back(line);
                w_order.push_back(line);
                aw_next[p]++;
                aw_taken[p] = 1'b1;
            end
            if (slv_w_valid_i[p] && slv_w_ready_o[p]) begin
                line = port_lines[p][w_next[p]];
                if (w_beat[p] == t_len[line]) begin
                    w_beat[p] = 0;
                    w_next[p]++;
                end else begin
                    w_beat[p]++;
                end
            end
            if (slv_b_valid_o[p] && slv_b_ready_i[p]) begin
                if (require(b_next[p] < port_lines[p].size(),
                            $sformatf("extra B on slave port %0d", p))) begin
                    line = port_lines[p][b_next[p]];   // Issue order per port
                    check_value($sformatf("slv_b_o[%0d].id", p), slv_b_o[p].id, t_id[line]);
                    check_value($sformatf("slv_b_o[%0d].resp", p), slv_b_o[p].resp,
                                t_resp[line]);
                    b_next[p]++;
                    b_count++;
                end
            end
        end
    endtask

    task automatic sample_master_side();
        int line;
        if (mst_aw_valid_o && mst_aw_ready_i) begin
            mst_aw_count++;
            if (w_beat_total == 0) begin
                aw_before_w++;
            end
            if (require(aw_order.size() > 0, "master AW with no slave AW granted")) begin
                line = aw_order.pop_front();
                check_value("mst_aw_o.id", mst_aw_o.id, {t_port[line], t_id[line]});
                check_value("mst_aw_o.addr", mst_aw_o.addr, t_addr[line]);
                check_value("mst_aw_o.len", mst_aw_o.len, t_len[line]);
                t_mst_id[line]  = mst_aw_o.id;
                t_aw_done[line] = 1'b1;
                if (t_w_done[line]) begin
                    b_pending.push_back(line);
                end
            end
            void'(require(aw_before_w <= MaxWTrans + 2, "too many AWs before the first W"));
            void'(require(mst_aw_count - burst_count <= MaxWTrans + 2,
                          "too many writes outstanding at the master"));
        end
        if (mst_w_valid_o && mst_w_ready_i) begin
            w_beat_total++;
            if (require(w_order.size() > 0, "master W beat with no AW granted")) begin
                line = w_order[0];
                check_value("mst_w_o.data", mst_w_o.data, beat_data(line, mst_beat));
                check_value("mst_w_o.strb", mst_w_o.strb, 4'hf);
                check_value("mst_w_o.last", mst_w_o.last, mst_beat == t_len[line]);
                if (mst_beat == t_len[line]) begin  // Burst complete
                    void'(w_order.pop_front());
                    mst_beat       = 0;
                    burst_count++;
                    t_w_done[line] = 1'b1;
                    if (t_aw_done[line]) begin
                        b_pending.push_back(line);
                    end
                end else begin
                    mst_beat++;
                end
            end
        end
        if (mst_b_valid_i) begin
            line = b_pending[0];
            check_value("slv_b_valid_o", slv_b_valid_o, 4'b0001 << t_port[line]);
            check_value("mst_b_ready_o", mst_b_ready_o, slv_b_ready_i[t_port[line]]);
            if (mst_b_ready_o) begin
                void'(b_pending.pop_front());
                b_taken = 1'b1;
            end
        end else begin
            check_value("slv_b_valid_o", slv_b_valid_o, '0);
        end
    endtask

    // ----------------------------------------
    // Driving just after the rising edge
    // ----------------------------------------
    task automatic drive_inputs();
        int line;
        bit stall;
        stall = (cycle_count < StallCycles);
        for (int p = 0; p < NumSlvPorts; p++) begin
            if (aw_taken[p]) begin
                slv_aw_valid_i[p] = 1'b0;
                aw_taken[p]       = 1'b0;
            end
            // Random gap before each new AW
            if (!slv_aw_valid_i[p] && aw_next[p] < port_lines[p].size()
                    && ($urandom % 2) == 0) begin
                line = port_lines[p][aw_next[p]];
                slv_aw_valid_i[p] = 1'b1;
                slv_aw_i[p].id    = t_id[line];
                slv_aw_i[p].addr  = t_addr[line];
                slv_aw_i[p].len   = t_len[line];
            end
            slv_w_valid_i[p] = (w_next[p] < aw_next[p]);   // Only after its AW
            if (slv_w_valid_i[p]) begin
                line = port_lines[p][w_next[p]];
                slv_w_i[p].data = beat_data(line, w_beat[p]);
                slv_w_i[p].strb = 4'hf;
                slv_w_i[p].last = (w_beat[p] == t_len[line]);
            end
            slv_b_ready_i[p] = ($urandom % 4) != 0;
        end
        mst_aw_ready_i = stall ? 1'b1 : (($urandom % 4) != 0);
        mst_w_ready_i  = stall ? 1'b0 : (($urandom % 4) != 0);
        if (b_taken) begin
            mst_b_valid_i = 1'b0;
            b_taken       = 1'b0;
        end
        if (!mst_b_valid_i && b_pending.size() > 0 && ($urandom % 2) == 0) begin
            mst_b_valid_i = 1'b1;
            mst_b_i.id    = t_mst_id[b_pending[0]];
            mst_b_i.resp  = t_resp[b_pending[0]];
        end
    endtask

    task automatic final_checks();
        void'(require(num_lines > 0, "input file holds no transactions"));
        for (int p = 0; p < NumSlvPorts; p++) begin
            check_value($sformatf("AW count on port %0d", p), aw_next[p], port_lines[p].size());
            check_value($sformatf("W bursts on port %0d", p), w_next[p], port_lines[p].size());
            check_value($sformatf("B count on port %0d", p), b_next[p], port_lines[p].size());
        end
        check_value("master AW count", mst_aw_count, num_lines);
        check_value("master W bursts", burst_count, num_lines);
        void'(require(aw_order.size() == 0 && w_order.size() == 0 && b_pending.size() == 0,
                      "writes still pending at the end of the run"));
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int drain;
        bit first;
        void'($urandom(32'h4936_4b25));
        clk_i          = 1'b0;
        rst_i          = 1'b1;
        slv_aw_i       = '0;
        slv_aw_valid_i = '0;
        slv_w_i        = '0;
        slv_w_valid_i  = '0;
        slv_b_ready_i  = '0;
        mst_aw_ready_i = 1'b0;
        mst_w_ready_i  = 1'b0;
        mst_b_i        = '0;
        mst_b_valid_i  = 1'b0;
        value_errors   = 0;
        other_errors   = 0;
        load_transactions();
        loaded = 1'b1;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk_i);
            if (i > 0) begin
                check_idle_outputs();   // Registers are known after the first edge
            end
        end
        #1 rst_i = 1'b0;
        first = 1'b1;
        drain = 0;
        while (drain < 20) begin
            @(posedge clk_i);
            if (first) begin
                check_idle_outputs();
            end
            first = 1'b0;
            sample_slave_side();
            sample_master_side();
            cycle_count++;
            if (b_count >= num_lines) begin
                drain++;                // Watch for late duplicates
            end
            #1;
            drive_inputs();
        end
        final_checks();
        $display("Error counts: %0d wrong values, %0d other failures",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the number of writes
    initial begin
        wait (loaded);
        repeat (num_lines * 200 + 100) @(posedge clk_i);
        other_errors++;
        $display("ERROR t=%0t: run did not finish in %0d cycles", $time, num_lines * 200 + 100);
        $display("Error counts: %0d wrong values, %0d other failures",
                 value_errors, other_errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: axi_mux.f
design/axi_mux_pkg.sv
design/axi_rr_arbiter.sv
design/axi_spill_register.sv
design/axi_w_route_fifo.sv
design/axi_aw_channel.sv
design/axi_w_channel.sv
design/axi_b_channel.sv
design/axi_mux_top.sv
tb/axi_mux_tb.sv

// File: tb/axi_mux_input.txt
# port id addr len resp, all hex, one write per line
# W beat k carries data {port, id, addr[7:0], k}
0 3 00001000 03 0
1 5 20000040 00 0
2 a 30000100 07 2
3 f 4000fff0 01 0
0 3 00001010 00 1
1 0 20000080 02 0
2 a 30000120 00 0
3 1 40000010 05 3
0 7 000010a4 01 0
1 5 200000c0 00 2
2 4 30000140 03 0
3 f 40000020 00 0
0 0 00001100 07 0
1 c 20000100 01 0
2 4 30000160 00 1
3 2 40000030 02 0
0 3 00001200 00 2
1 c 20000140 04 0
2 9 30000180 01 0
3 2 40000040 00 0
0 e 00001300 02 3
1 0 20000180 00 0
2 9 300001a0 06 0
3 8 40000050 01 2
0 1 00001400 00 0
1 6 200001c0 03 0
